// ==== bbc_sound_pkg.sv ====
package bbc_sound_pkg;

	// Number of square wave tone channels
	localparam int NUM_TONE = 3;

	// 4 MHz enables per tone tick, so one tick every 128 master clocks
	localparam int PRESCALE = 16;

	// Amplitude per attenuation code in 2 dB steps, code 15 is silence
	localparam logic [6:0] VOL_TABLE [16] = '{
		7'd42, 7'd33, 7'd27, 7'd21,
		7'd17, 7'd13, 7'd11, 7'd8,
		7'd7,  7'd5,  7'd4,  7'd3,
		7'd3,  7'd2,  7'd2,  7'd0
	};

	// IC32 addressable latch, bit 0 at the bottom
	typedef struct packed {
		logic       shift_lock_led_n;
		logic       caps_lock_led_n;
		logic [1:0] disp_addr_offs;
		logic       keyb_enable_n;
		logic       speech_read_n;
		logic       speech_write_n;
		logic       sound_we_n;
	} ic32_t;

	// SN76489 register numbers as carried in a latch byte
	typedef enum logic [2:0] {
		tone0_freq,
		tone0_att,
		tone1_freq,
		tone1_att,
		tone2_freq,
		tone2_att,
		noise_ctrl,
		noise_att
	} psg_reg_e;

	// Settings of one tone channel
	typedef struct packed {
		logic [9:0] period;
		logic [3:0] att;
	} tone_cfg_t;

	typedef logic signed [7:0] chan_level_t;

	// Unsigned offset sample for the DAC
	typedef logic [15:0] audio_sample_t;

endpackage

// ==== clock_enables.sv ====
`timescale 1ns/1ps

module clock_enables (
	input  logic CLK32M_I,
	input  logic arst_n,
	output logic mhz4_clken,
	output logic tone_tick
);
	import bbc_sound_pkg::*;

	logic [2:0]                      div8_q;
	logic [$clog2(PRESCALE)-1:0]     pre_q;

	// Free running divider, enable registered so it is low in reset
	always_ff @(posedge CLK32M_I or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div8_q     <= '0;
			mhz4_clken <= 1'b0;
			pre_q      <= '0;
		end
		else
		begin
			div8_q     <= div8_q + 3'd1;
			mhz4_clken <= (div8_q == 3'd7);
			if (mhz4_clken)
				pre_q <= pre_q + 1'b1;
		end
	end

	// Tick on the last enable of each prescaler round
	assign tone_tick = mhz4_clken && (pre_q == $bits(pre_q)'(PRESCALE - 1));

endmodule

// ==== ic32_latch.sv ====
`timescale 1ns/1ps

module ic32_latch (
	input  logic                 CLK32M_I,
	input  logic                 arst_n,
	input  logic [7:0]           pb,
	output bbc_sound_pkg::ic32_t ic32
);

	// Port B bits 2..0 address one latch bit and bit 3 gives its value
	always_ff @(posedge CLK32M_I or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ic32 <= '0;
		end
		else
		begin
			case (pb[2:0])
				3'd0: ic32.sound_we_n        <= pb[3];
				3'd1: ic32.speech_write_n    <= pb[3];
				3'd2: ic32.speech_read_n     <= pb[3];
				3'd3: ic32.keyb_enable_n     <= pb[3];
				3'd4: ic32.disp_addr_offs[0] <= pb[3];
				3'd5: ic32.disp_addr_offs[1] <= pb[3];
				3'd6: ic32.caps_lock_led_n   <= pb[3];
				3'd7: ic32.shift_lock_led_n  <= pb[3];
			endcase
		end
	end

endmodule

// ==== psg_register_file.sv ====
`timescale 1ns/1ps

module psg_register_file (
	input  logic                     CLK32M_I,
	input  logic                     arst_n,
	input  logic                     sound_we_n,
	input  logic [7:0]               data,
	output bbc_sound_pkg::tone_cfg_t tone_cfg [bbc_sound_pkg::NUM_TONE]
);
	import bbc_sound_pkg::*;

	logic       we_n_q;
	logic       we_fall;
	psg_reg_e   last_reg;
	logic [2:0] cur_idx;
	psg_reg_e   cur_reg;
	logic [1:0] chan;

	// Write strobe edge, the latch powers up low so no write after reset
	assign we_fall = we_n_q && !sound_we_n;

	// Latch bytes name the register, data bytes reuse the last one
	assign cur_idx = data[7] ? data[6:4] : last_reg;
	assign cur_reg = psg_reg_e'(cur_idx);
	assign chan    = cur_idx[2:1];

	always_ff @(posedge CLK32M_I or negedge arst_n)
	begin
		if (!arst_n)
		begin
			we_n_q <= 1'b0;
		end
		else
		begin
			we_n_q <= sound_we_n;
		end
	end

	always_ff @(posedge CLK32M_I or negedge arst_n)
	begin
		if (!arst_n)
		begin
			last_reg <= tone0_freq;
			for (int i = 0; i < NUM_TONE; i++)
			begin
				tone_cfg[i] <= '{period: 10'd0, att: 4'hF};
			end
		end
		else if (we_fall)
		begin
			if (data[7])
				last_reg <= cur_reg;

			case (cur_reg)
				tone0_freq, tone1_freq, tone2_freq:
				begin
					// Low nibble from a latch byte, upper six bits from a data byte
					if (data[7])
						tone_cfg[chan].period[3:0] <= data[3:0];
					else
						tone_cfg[chan].period[9:4] <= data[5:0];
				end
				tone0_att, tone1_att, tone2_att:
				begin
					tone_cfg[chan].att <= data[3:0];
				end
				default:
				begin
					// No noise channel here
				end
			endcase
		end
	end

endmodule

// ==== psg_tone_channel.sv ====
`timescale 1ns/1ps

module psg_tone_channel (
	input  logic                       CLK32M_I,
	input  logic                       arst_n,
	input  logic                       tone_tick,
	input  bbc_sound_pkg::tone_cfg_t   cfg,
	output bbc_sound_pkg::chan_level_t level
);
	import bbc_sound_pkg::*;

	logic [9:0]  count_q;
	logic        tone_q;
	logic [6:0]  amp;
	chan_level_t mag;

	// Reload on expiry; a period of 0 wraps to 1023 and so lasts 1024 ticks
	always_ff @(posedge CLK32M_I or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count_q <= '0;
			tone_q  <= 1'b1;
		end
		else if (tone_tick)
		begin
			if (count_q == 10'd1)
			begin
				count_q <= cfg.period;
				tone_q  <= !tone_q;
			end
			else
			begin
				count_q <= count_q - 10'd1;
			end
		end
	end

	// Attenuation takes effect at once
	assign amp = VOL_TABLE[cfg.att];
	assign mag = chan_level_t'({1'b0, amp});

	assign level = tone_q ? mag : -mag;

endmodule

// ==== psg_mixer.sv ====
`timescale 1ns/1ps

module psg_mixer (
	input  logic                         CLK32M_I,
	input  logic                         arst_n,
	input  logic                         mhz4_clken,
	input  bbc_sound_pkg::chan_level_t   levels [bbc_sound_pkg::NUM_TONE],
	output bbc_sound_pkg::audio_sample_t sample
);
	import bbc_sound_pkg::*;

	chan_level_t sum;

	// Three channels of at most 42 each stay inside 8 signed bits
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < NUM_TONE; i++)
		begin
			sum = sum + levels[i];
		end
	end

	// Signed byte to offset binary in the upper half of the word
	always_ff @(posedge CLK32M_I or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sample <= 16'h8000;
		end
		else if (mhz4_clken)
		begin
			sample <= {~sum[7], sum[6:0], 8'h00};
		end
	end

endmodule

// ==== bbc_sound.sv ====
`timescale 1ns/1ps

module bbc_sound (
	input  logic                         CLK32M_I,
	input  logic                         arst_n,
	input  logic [7:0]                   sys_pa,
	input  logic [7:0]                   sys_pb,
	output bbc_sound_pkg::ic32_t         ic32,
	output bbc_sound_pkg::audio_sample_t audio_l,
	output bbc_sound_pkg::audio_sample_t audio_r
);
	import bbc_sound_pkg::*;

	logic          mhz4_clken;
	logic          tone_tick;
	tone_cfg_t     tone_cfg [NUM_TONE];
	chan_level_t   levels [NUM_TONE];
	audio_sample_t mix_sample;

	clock_enables u_clock_enables (
		.CLK32M_I   (CLK32M_I),
		.arst_n     (arst_n),
		.mhz4_clken (mhz4_clken),
		.tone_tick  (tone_tick)
	);

	// System VIA port B drives the addressable latch
	ic32_latch u_ic32_latch (
		.CLK32M_I (CLK32M_I),
		.arst_n   (arst_n),
		.pb       (sys_pb),
		.ic32     (ic32)
	);

	// Port A carries the sound byte, IC32 bit 0 strobes it in
	psg_register_file u_psg_register_file (
		.CLK32M_I   (CLK32M_I),
		.arst_n     (arst_n),
		.sound_we_n (ic32.sound_we_n),
		.data       (sys_pa),
		.tone_cfg   (tone_cfg)
	);

	for (genvar i = 0; i < NUM_TONE; i++)
	begin : g_tone
		psg_tone_channel u_psg_tone_channel (
			.CLK32M_I  (CLK32M_I),
			.arst_n    (arst_n),
			.tone_tick (tone_tick),
			.cfg       (tone_cfg[i]),
			.level     (levels[i])
		);
	end

	psg_mixer u_psg_mixer (
		.CLK32M_I   (CLK32M_I),
		.arst_n     (arst_n),
		.mhz4_clken (mhz4_clken),
		.levels     (levels),
		.sample     (mix_sample)
	);

	// Mono source on both DAC channels
	assign audio_l = mix_sample;
	assign audio_r = mix_sample;

endmodule

// ==== bbc_sound_assertions.sv ====
`timescale 1ns/1ps

module bbc_sound_assertions (
	input logic                         CLK32M_I,
	input logic                         arst_n,
	input logic                         mhz4_clken,
	input bbc_sound_pkg::ic32_t         ic32,
	input bbc_sound_pkg::audio_sample_t audio_l,
	input bbc_sound_pkg::audio_sample_t audio_r
);

	int fail_count = 0;

	// Both DAC channels carry the same mono sample
	a_mono: assert property (@(posedge CLK32M_I) audio_l == audio_r)
	else
	begin
		fail_count++;
		$error("audio_l and audio_r differ");
	end

	// Latch cleared while reset is held
	a_ic32_reset: assert property (@(posedge CLK32M_I) !arst_n |-> ic32 == '0)
	else
	begin
		fail_count++;
		$error("ic32 not zero during reset");
	end

	// Sample register only loads on the 4 MHz enable
	a_audio_clken: assert property (@(posedge CLK32M_I) disable iff (!arst_n)
		$changed(audio_l) |-> $past(mhz4_clken))
	else
	begin
		fail_count++;
		$error("audio changed without a preceding mhz4_clken");
	end

endmodule

bind bbc_sound bbc_sound_assertions u_bbc_sound_assertions (
	.CLK32M_I   (CLK32M_I),
	.arst_n     (arst_n),
	.mhz4_clken (mhz4_clken),
	.ic32       (ic32),
	.audio_l    (audio_l),
	.audio_r    (audio_r)
);

// ==== tb_bbc_sound.sv ====
`timescale 1ns/1ps

module tb_bbc_sound;
	import bbc_sound_pkg::*;

	// Longest half period of 1024 ticks of 128 clocks plus the mixer lag
	localparam int TIMEOUT_CYCLES = 1100 * 8 * PRESCALE;

	// One write and the state it should leave behind
	typedef struct {
		logic       reset_before;
		logic [7:0] pb;
		logic       strobe;
		logic [7:0] pa;
		int         chan;
		tone_cfg_t  cfg;
		ic32_t      ic32;
		int         mag;
		int         half;
	} row_t;

	logic          CLK32M_I;
	logic          arst_n;
	logic [7:0]    sys_pa;
	logic [7:0]    sys_pb;
	ic32_t         ic32;
	audio_sample_t audio_l;
	audio_sample_t audio_r;

	row_t rows [$];
	int   n_checks;
	int   n_errors;
	int   n_timeouts;
	int   n_assert;

	bbc_sound uut (
		.CLK32M_I (CLK32M_I),
		.arst_n   (arst_n),
		.sys_pa   (sys_pa),
		.sys_pb   (sys_pb),
		.ic32     (ic32),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

	initial
	begin
		CLK32M_I = 1'b0;
		forever
		begin
			#50 CLK32M_I = ~CLK32M_I;
		end
	end

	// Drive and sample 10 ns after each rising edge
	task automatic step(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge CLK32M_I);
			#10;
		end
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		sys_pa = 8'h00;
		sys_pb = 8'h00;
		step(5);
		arst_n = 1'b1;
		step(1);
	endtask

	task automatic check_sample(input audio_sample_t act, input audio_sample_t exp);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("error at %0t: audio sample 0x%04h, expected 0x%04h", $time, act, exp);
		end
	endtask

	task automatic check_ic32(input ic32_t act, input ic32_t exp);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("error at %0t: ic32 0x%02h, expected 0x%02h", $time, act, exp);
		end
	endtask

	task automatic check_tone_cfg(input tone_cfg_t act, input tone_cfg_t exp, input int chan);
		n_checks++;
		if (act !== exp)
		begin
			n_errors++;
			$display("error at %0t: channel %0d period %0d att %0d, expected period %0d att %0d",
				$time, chan, act.period, act.att, exp.period, exp.att);
		end
	endtask

	task automatic check_half_period(input int act, input int exp);
		n_checks++;
		if (act != exp)
		begin
			n_errors++;
			$display("error at %0t: half period %0d cycles, expected %0d", $time, act, exp);
		end
	endtask

	// Magnitude from the table and sign from the current tone phase
	task automatic check_level(input int mag);
		audio_sample_t exp;
		if (audio_l >= 16'h8000)
			exp = audio_sample_t'(32768 + mag * 256);
		else
			exp = audio_sample_t'(32768 - mag * 256);
		check_sample(audio_l, exp);
		check_sample(audio_r, exp);
	endtask

	task automatic wait_audio_change(output int cycles);
		audio_sample_t prev;
		prev   = audio_l;
		cycles = 0;
		while (audio_l === prev && cycles < TIMEOUT_CYCLES)
		begin
			step(1);
			cycles++;
		end
		if (audio_l === prev)
		begin
			n_timeouts++;
			$display("timeout: the audio did not change within %0d cycles", TIMEOUT_CYCLES);
		end
	endtask

	// IC32 bit 0 high then low so the falling edge writes sys_pa
	task automatic strobe_sound_write();
		sys_pb = 8'h08;
		step(2);
		sys_pb = 8'h00;
		step(2);
	endtask

	task automatic add_row(input logic rst, input logic [7:0] pb, input logic strobe,
		input logic [7:0] pa, input int chan, input logic [9:0] period,
		input logic [3:0] att, input logic [7:0] exp_ic32, input int mag,
		input int half_ticks);
		row_t r;
		r.reset_before = rst;
		r.pb           = pb;
		r.strobe       = strobe;
		r.pa           = pa;
		r.chan         = chan;
		r.cfg          = '{period: period, att: att};
		r.ic32         = ic32_t'(exp_ic32);
		r.mag          = mag;
		r.half         = half_ticks * 8 * PRESCALE;
		rows.push_back(r);
	endtask

	task automatic load_rows();
		// rst, pb, strobe, pa, chan, period, att, ic32, magnitude, half period ticks
		add_row(1, 8'h00, 0, 8'h00, 0, 10'd0, 4'hF, 8'h00, 0, 0);
		// IC32 bits one at a time including LEDs and display offset
		add_row(0, 8'h0E, 0, 8'h00, 0, 10'd0, 4'hF, 8'h40, 0, 0);
		add_row(0, 8'h0F, 0, 8'h00, 0, 10'd0, 4'hF, 8'hC0, 0, 0);
		add_row(0, 8'h0C, 0, 8'h00, 0, 10'd0, 4'hF, 8'hD0, 0, 0);
		add_row(0, 8'h0D, 0, 8'h00, 0, 10'd0, 4'hF, 8'hF0, 0, 0);
		add_row(0, 8'h06, 0, 8'h00, 0, 10'd0, 4'hF, 8'hB0, 0, 0);
		add_row(0, 8'h0B, 0, 8'h00, 0, 10'd0, 4'hF, 8'hB8, 0, 0);
		add_row(0, 8'h09, 0, 8'h00, 0, 10'd0, 4'hF, 8'hBA, 0, 0);
		add_row(0, 8'h0A, 0, 8'h00, 0, 10'd0, 4'hF, 8'hBE, 0, 0);
		add_row(0, 8'h08, 0, 8'h00, 0, 10'd0, 4'hF, 8'hBF, 0, 0);
		add_row(0, 8'h07, 0, 8'h00, 0, 10'd0, 4'hF, 8'h3F, 0, 0);
		add_row(0, 8'h03, 0, 8'h00, 0, 10'd0, 4'hF, 8'h37, 0, 0);
		// Channel 0 period 18 then 5 at full volume
		add_row(0, 8'h08, 1, 8'h82, 0, 10'd2, 4'hF, 8'h36, 0, 0);
		add_row(0, 8'h08, 1, 8'h01, 0, 10'd18, 4'hF, 8'h36, 0, 0);
		add_row(0, 8'h08, 1, 8'h90, 0, 10'd18, 4'h0, 8'h36, VOL_TABLE[0], 18);
		add_row(0, 8'h08, 1, 8'h85, 0, 10'd21, 4'h0, 8'h36, VOL_TABLE[0], 0);
		add_row(0, 8'h08, 1, 8'h00, 0, 10'd5, 4'h0, 8'h36, VOL_TABLE[0], 5);
		// Attenuation sweep
		add_row(0, 8'h08, 1, 8'h93, 0, 10'd5, 4'h3, 8'h36, VOL_TABLE[3], 0);
		add_row(0, 8'h08, 1, 8'h97, 0, 10'd5, 4'h7, 8'h36, VOL_TABLE[7], 0);
		add_row(0, 8'h08, 1, 8'h9A, 0, 10'd5, 4'hA, 8'h36, VOL_TABLE[10], 0);
		add_row(0, 8'h08, 1, 8'h9D, 0, 10'd5, 4'hD, 8'h36, VOL_TABLE[13], 0);
		add_row(0, 8'h08, 1, 8'h9F, 0, 10'd5, 4'hF, 8'h36, VOL_TABLE[15], 0);
		add_row(0, 8'h08, 1, 8'h90, 0, 10'd5, 4'h0, 8'h36, VOL_TABLE[0], 0);
		// Port A moves with no strobe edge and then noise register writes
		add_row(0, 8'h08, 0, 8'h9F, 0, 10'd5, 4'h0, 8'h37, VOL_TABLE[0], 0);
		add_row(0, 8'h08, 0, 8'h91, 0, 10'd5, 4'h0, 8'h37, VOL_TABLE[0], 0);
		add_row(0, 8'h08, 1, 8'hE3, 0, 10'd5, 4'h0, 8'h36, VOL_TABLE[0], 0);
		add_row(0, 8'h08, 1, 8'hF7, 0, 10'd5, 4'h0, 8'h36, VOL_TABLE[0], 0);
		add_row(0, 8'h08, 1, 8'h3F, 0, 10'd5, 4'h0, 8'h36, VOL_TABLE[0], 5);
		// Fresh reset keeps the three channels in phase
		add_row(1, 8'h08, 1, 8'h83, 0, 10'd3, 4'hF, 8'h00, 0, 0);
		add_row(0, 8'h08, 1, 8'h00, 0, 10'd3, 4'hF, 8'h00, 0, 0);
		add_row(0, 8'h08, 1, 8'hA3, 1, 10'd3, 4'hF, 8'h00, 0, 0);
		add_row(0, 8'h08, 1, 8'h00, 1, 10'd3, 4'hF, 8'h00, 0, 0);
		add_row(0, 8'h08, 1, 8'hC3, 2, 10'd3, 4'hF, 8'h00, 0, 0);
		add_row(0, 8'h08, 1, 8'h00, 2, 10'd3, 4'hF, 8'h00, 0, 0);
		add_row(0, 8'h08, 1, 8'h90, 0, 10'd3, 4'h0, 8'h00, VOL_TABLE[0], 0);
		add_row(0, 8'h08, 1, 8'hB0, 1, 10'd3, 4'h0, 8'h00, 2 * VOL_TABLE[0], 0);
		add_row(0, 8'h08, 1, 8'hD0, 2, 10'd3, 4'h0, 8'h00, 3 * VOL_TABLE[0], 3);
	endtask

	task automatic apply_row(input row_t r);
		int a_cycles;
		int b_cycles;
		if (r.reset_before)
		begin
			apply_reset();
			check_ic32(ic32, '0);
			check_sample(audio_l, 16'h8000);
		end
		sys_pa = r.pa;
		sys_pb = r.pb;
		step(2);
		if (r.strobe)
			strobe_sound_write();
		// Let the mixer pick up the new level
		step(16);
		check_ic32(ic32, r.ic32);
		check_tone_cfg(uut.tone_cfg[r.chan], r.cfg, r.chan);
		check_level(r.mag);
		if (r.half > 0)
		begin
			// First edge may still run out the old count
			wait_audio_change(a_cycles);
			wait_audio_change(b_cycles);
			check_half_period(b_cycles, r.half);
			check_level(r.mag);
		end
	endtask

	initial
	begin
		arst_n     = 1'b1;
		sys_pa     = 8'h00;
		sys_pb     = 8'h00;
		n_checks   = 0;
		n_errors   = 0;
		n_timeouts = 0;
		load_rows();
		#10;
		foreach (rows[i])
		begin
			apply_row(rows[i]);
		end
		n_assert = uut.u_bbc_sound_assertions.fail_count;
		$display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			n_checks, n_errors, n_timeouts, n_assert);
		if (n_errors == 0 && n_timeouts == 0 && n_assert == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== bbc_sound.f ====
bbc_sound_pkg.sv
clock_enables.sv
ic32_latch.sv
psg_register_file.sv
psg_tone_channel.sv
psg_mixer.sv
bbc_sound.sv
bbc_sound_assertions.sv
tb_bbc_sound.sv
